/* compile.f */
+incdir+design
design/mem_axi_pkg.sv
design/req_arbiter.sv
design/axi_master_bridge.sv
design/axi_sram_slave.sv
design/mem_subsys_top.sv
test/tb_mem_subsys.sv

/* design/axi_master_bridge.sv */
// axi4 master bridge
`timescale 1ns/1ps
`include "mem_axi_cfg.svh"

module axi_master_bridge (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  mem_axi_pkg::bus_req_t req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output mem_axi_pkg::mem_rsp_t rsp_o,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output mem_axi_pkg::axi_ar_t  ar_o,
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    input  mem_axi_pkg::axi_r_t   r_i,
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    output mem_axi_pkg::axi_aw_t  aw_o,
    output logic                  aw_valid_o,
    input  logic                  aw_ready_i,
    output mem_axi_pkg::axi_w_t   w_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    input  mem_axi_pkg::axi_b_t   b_i,
    input  logic                  b_valid_i,
    output logic                  b_ready_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_AR,
        S_RD,
        S_WR,
        S_B
    } state_e;

    state_e                state_q;
    mem_axi_pkg::bus_req_t req_q;
    logic                  aw_pend_q;
    logic                  w_pend_q;
    logic                  aw_hs;
    logic                  w_hs;
    logic                  wr_done;

    assign req_ready_o = (state_q == S_IDLE);

    // one address payload serves both ar and aw
    always_comb begin
        ar_o       = '0;
        ar_o.id    = req_q.id;
        ar_o.addr  = req_q.req.addr;
        ar_o.len   = req_q.burst ? 8'(`LINE_BEATS - 1) : 8'd0;
        ar_o.size  = 3'($clog2(`MEM_STRB_W));   // full 8-byte beats
        ar_o.burst = mem_axi_pkg::BURST_INCR;
    end

    assign aw_o = ar_o;

    assign w_o.data = req_q.req.wdata;
    assign w_o.strb = req_q.req.wstrb;
    assign w_o.last = 1'b1;   // stores are single beat

    assign ar_valid_o = (state_q == S_AR);
    assign aw_valid_o = aw_pend_q;
    assign w_valid_o  = w_pend_q;
    assign r_ready_o  = (state_q == S_RD) && rsp_ready_i;   // straight back-pressure
    assign b_ready_o  = (state_q == S_B) && rsp_ready_i;

    assign aw_hs   = aw_valid_o && aw_ready_i;
    assign w_hs    = w_valid_o && w_ready_i;
    assign wr_done = (!aw_pend_q || aw_hs) && (!w_pend_q || w_hs);

    always_comb begin
        rsp_o       = '0;
        rsp_valid_o = 1'b0;
        if (state_q == S_RD) begin
            rsp_valid_o = r_valid_i;
            rsp_o.rdata = r_i.data;
            rsp_o.err   = (r_i.resp == mem_axi_pkg::DECERR);
            rsp_o.last  = r_i.last;
        end else if (state_q == S_B) begin
            // write status goes out as one last beat
            rsp_valid_o = b_valid_i;
            rsp_o.err   = (b_i.resp == mem_axi_pkg::DECERR);
            rsp_o.last  = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= S_IDLE;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_valid_i) begin
                        state_q   <= req_i.req.write ? S_WR : S_AR;
                        aw_pend_q <= req_i.req.write;
                        w_pend_q  <= req_i.req.write;
                    end
                end
                S_AR: begin
                    if (ar_ready_i) state_q <= S_RD;
                end
                S_RD: begin
                    if (r_valid_i && rsp_ready_i && r_i.last) state_q <= S_IDLE;
                end
                S_WR: begin
                    // aw and w may complete in either order
                    if (aw_hs) aw_pend_q <= 1'b0;
                    if (w_hs) w_pend_q <= 1'b0;
                    if (wr_done) state_q <= S_B;
                end
                S_B: begin
                    if (b_valid_i && rsp_ready_i) state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) req_q <= req_i;
    end

endmodule

/* design/axi_sram_slave.sv */
// axi4 sram slave
`timescale 1ns/1ps
`include "mem_axi_cfg.svh"

module axi_sram_slave (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  mem_axi_pkg::axi_ar_t ar_i,
    input  logic                 ar_valid_i,
    output logic                 ar_ready_o,
    output mem_axi_pkg::axi_r_t  r_o,
    output logic                 r_valid_o,
    input  logic                 r_ready_i,
    input  mem_axi_pkg::axi_aw_t aw_i,
    input  logic                 aw_valid_i,
    output logic                 aw_ready_o,
    input  mem_axi_pkg::axi_w_t  w_i,
    input  logic                 w_valid_i,
    output logic                 w_ready_o,
    output mem_axi_pkg::axi_b_t  b_o,
    output logic                 b_valid_o,
    input  logic                 b_ready_i
);

    localparam int OFF_W = $clog2(`MEM_STRB_W);
    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam logic [`MEM_ADDR_W-1:0] BEAT_BYTES = `MEM_ADDR_W'(`MEM_STRB_W);

    logic [`MEM_DATA_W-1:0] mem_q [`MEM_WORDS];

    logic                   r_valid_q;
    mem_axi_pkg::axi_r_t    r_q;
    logic [`MEM_ADDR_W-1:0] rd_addr_q;   // next beat address
    logic [`MEM_ADDR_W-1:0] rd_addr;
    logic [7:0]             rd_len_q;
    logic [7:0]             rd_cnt_q;
    logic                   ar_hs;
    logic                   r_hs;
    logic                   rd_load;

    logic                   aw_have_q;
    logic [`MEM_ADDR_W-1:0] wr_addr_q;
    logic [`MEM_ID_W-1:0]   wr_id_q;
    logic                   b_valid_q;
    mem_axi_pkg::axi_b_t    b_q;
    logic [`MEM_ADDR_W-1:0] wr_addr;
    logic                   wr_bad;
    logic                   aw_hs;
    logic                   w_hs;

    function automatic logic in_range(input logic [`MEM_ADDR_W-1:0] addr);
        return (addr >> OFF_W) < `MEM_WORDS;
    endfunction

    // read side
    assign ar_ready_o = !r_valid_q;
    assign ar_hs      = ar_valid_i && ar_ready_o;
    assign r_hs       = r_valid_q && r_ready_i;
    assign rd_load    = ar_hs || (r_hs && !r_q.last);
    assign rd_addr    = ar_hs ? ar_i.addr : rd_addr_q;
    assign r_valid_o  = r_valid_q;
    assign r_o        = r_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            r_valid_q <= 1'b0;
            rd_len_q  <= '0;
            rd_cnt_q  <= '0;
        end else if (ar_hs) begin
            r_valid_q <= 1'b1;
            rd_len_q  <= ar_i.len;
            rd_cnt_q  <= '0;
        end else if (r_hs) begin
            if (r_q.last) r_valid_q <= 1'b0;
            else rd_cnt_q <= rd_cnt_q + 8'd1;
        end
    end

    // beat is registered so it holds under back-pressure
    always_ff @(posedge clk_i) begin
        if (rd_load) begin
            r_q.data  <= in_range(rd_addr) ? mem_q[rd_addr[OFF_W +: IDX_W]] : '0;
            r_q.resp  <= in_range(rd_addr) ? mem_axi_pkg::OKAY : mem_axi_pkg::DECERR;
            r_q.last  <= ar_hs ? (ar_i.len == 8'd0) : (rd_cnt_q + 8'd1 == rd_len_q);
            rd_addr_q <= rd_addr + BEAT_BYTES;
        end
        if (ar_hs) r_q.id <= ar_i.id;
    end

    // write side accepts w with aw or after it
    assign aw_ready_o = !aw_have_q && !b_valid_q;
    assign w_ready_o  = (aw_have_q || aw_valid_i) && !b_valid_q;
    assign aw_hs      = aw_valid_i && aw_ready_o;
    assign w_hs       = w_valid_i && w_ready_o;
    assign wr_addr    = aw_have_q ? wr_addr_q : aw_i.addr;
    assign wr_bad     = !in_range(wr_addr);
    assign b_valid_o  = b_valid_q;
    assign b_o        = b_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            aw_have_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (w_hs && w_i.last) aw_have_q <= 1'b0;
            else if (aw_hs) aw_have_q <= 1'b1;
            if (w_hs && w_i.last) b_valid_q <= 1'b1;
            else if (b_ready_i) b_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_hs) wr_id_q <= aw_i.id;
        if (w_hs) wr_addr_q <= wr_addr + BEAT_BYTES;
        else if (aw_hs) wr_addr_q <= aw_i.addr;
        if (w_hs && w_i.last) begin
            b_q.id   <= aw_have_q ? wr_id_q : aw_i.id;
            b_q.resp <= wr_bad ? mem_axi_pkg::DECERR : mem_axi_pkg::OKAY;
        end
    end

    // strobed store that drops out of range writes
    always_ff @(posedge clk_i) begin
        if (w_hs && in_range(wr_addr)) begin
            for (int i = 0; i < `MEM_STRB_W; i++) begin
                if (w_i.strb[i]) mem_q[wr_addr[OFF_W +: IDX_W]][8*i +: 8] <= w_i.data[8*i +: 8];
            end
        end
    end

endmodule

/* design/mem_axi_cfg.svh */
// memory subsystem configuration
`ifndef MEM_AXI_CFG_SVH
`define MEM_AXI_CFG_SVH

// byte address width
`define MEM_ADDR_W 32

// one 64-bit word per beat
`define MEM_DATA_W 64
`define MEM_STRB_W 8

`define MEM_ID_W 4

// beats per fetch line refill
`define LINE_BEATS 4

// sram depth in 64-bit words
`define MEM_WORDS 256

`endif

/* design/mem_axi_pkg.sv */
// memory subsystem types
`include "mem_axi_cfg.svh"

package mem_axi_pkg;

    localparam logic [1:0] BURST_INCR = 2'b01;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } axi_resp_e;

    // request as presented on the data port
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
        logic [`MEM_STRB_W-1:0] wstrb;
        logic                   write;
    } data_req_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] rdata;
        logic                   err;
        logic                   last;   // final beat of a transaction
    } mem_rsp_t;

    typedef struct packed {
        data_req_t             req;
        logic                  burst;  // line refill
        logic [`MEM_ID_W-1:0]  id;     // 0 fetch, 1 data
    } bus_req_t;

    typedef struct packed {
        logic [`MEM_ID_W-1:0]   id;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [7:0]             len;    // beats minus one
        logic [2:0]             size;
        logic [1:0]             burst;
    } axi_ar_t;

    // write address carries the same fields
    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] data;
        logic [`MEM_STRB_W-1:0] strb;
        logic                   last;
    } axi_w_t;

    typedef struct packed {
        logic [`MEM_ID_W-1:0]   id;
        logic [`MEM_DATA_W-1:0] data;
        axi_resp_e              resp;
        logic                   last;
    } axi_r_t;

    typedef struct packed {
        logic [`MEM_ID_W-1:0] id;
        axi_resp_e            resp;
    } axi_b_t;

endpackage

/* design/mem_subsys_top.sv */
// memory subsystem top
`timescale 1ns/1ps
`include "mem_axi_cfg.svh"

module mem_subsys_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`MEM_ADDR_W-1:0] fetch_addr_i,
    input  logic                   fetch_valid_i,
    output logic                   fetch_ready_o,
    output mem_axi_pkg::mem_rsp_t  fetch_rsp_o,
    output logic                   fetch_rsp_valid_o,
    input  logic                   fetch_rsp_ready_i,
    input  mem_axi_pkg::data_req_t data_req_i,
    input  logic                   data_valid_i,
    output logic                   data_ready_o,
    output mem_axi_pkg::mem_rsp_t  data_rsp_o,
    output logic                   data_rsp_valid_o,
    input  logic                   data_rsp_ready_i
);

    mem_axi_pkg::bus_req_t bus_req;
    logic                  bus_req_valid;
    logic                  bus_req_ready;
    mem_axi_pkg::mem_rsp_t bus_rsp;
    logic                  bus_rsp_valid;
    logic                  bus_rsp_ready;

    // axi4 channels between bridge and sram
    mem_axi_pkg::axi_ar_t  ar;
    logic                  ar_valid;
    logic                  ar_ready;
    mem_axi_pkg::axi_r_t   r;
    logic                  r_valid;
    logic                  r_ready;
    mem_axi_pkg::axi_aw_t  aw;
    logic                  aw_valid;
    logic                  aw_ready;
    mem_axi_pkg::axi_w_t   w;
    logic                  w_valid;
    logic                  w_ready;
    mem_axi_pkg::axi_b_t   b;
    logic                  b_valid;
    logic                  b_ready;

    req_arbiter u_arb (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .fetch_addr_i      (fetch_addr_i),
        .fetch_valid_i     (fetch_valid_i),
        .fetch_ready_o     (fetch_ready_o),
        .data_req_i        (data_req_i),
        .data_valid_i      (data_valid_i),
        .data_ready_o      (data_ready_o),
        .fetch_rsp_o       (fetch_rsp_o),
        .fetch_rsp_valid_o (fetch_rsp_valid_o),
        .fetch_rsp_ready_i (fetch_rsp_ready_i),
        .data_rsp_o        (data_rsp_o),
        .data_rsp_valid_o  (data_rsp_valid_o),
        .data_rsp_ready_i  (data_rsp_ready_i),
        .bus_req_o         (bus_req),
        .bus_req_valid_o   (bus_req_valid),
        .bus_req_ready_i   (bus_req_ready),
        .bus_rsp_i         (bus_rsp),
        .bus_rsp_valid_i   (bus_rsp_valid),
        .bus_rsp_ready_o   (bus_rsp_ready)
    );

    axi_master_bridge u_axi (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (bus_req),
        .req_valid_i (bus_req_valid),
        .req_ready_o (bus_req_ready),
        .rsp_o       (bus_rsp),
        .rsp_valid_o (bus_rsp_valid),
        .rsp_ready_i (bus_rsp_ready),
        .ar_o        (ar),
        .ar_valid_o  (ar_valid),
        .ar_ready_i  (ar_ready),
        .r_i         (r),
        .r_valid_i   (r_valid),
        .r_ready_o   (r_ready),
        .aw_o        (aw),
        .aw_valid_o  (aw_valid),
        .aw_ready_i  (aw_ready),
        .w_o         (w),
        .w_valid_o   (w_valid),
        .w_ready_i   (w_ready),
        .b_i         (b),
        .b_valid_i   (b_valid),
        .b_ready_o   (b_ready)
    );

    axi_sram_slave u_axi_slave (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ar_i       (ar),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .r_o        (r),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .aw_i       (aw),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_i        (w),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .b_o        (b),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready)
    );

endmodule

/* design/req_arbiter.sv */
// fetch and data port arbiter
`timescale 1ns/1ps
`include "mem_axi_cfg.svh"

module req_arbiter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`MEM_ADDR_W-1:0] fetch_addr_i,
    input  logic                   fetch_valid_i,
    output logic                   fetch_ready_o,
    input  mem_axi_pkg::data_req_t data_req_i,
    input  logic                   data_valid_i,
    output logic                   data_ready_o,
    output mem_axi_pkg::mem_rsp_t  fetch_rsp_o,
    output logic                   fetch_rsp_valid_o,
    input  logic                   fetch_rsp_ready_i,
    output mem_axi_pkg::mem_rsp_t  data_rsp_o,
    output logic                   data_rsp_valid_o,
    input  logic                   data_rsp_ready_i,
    output mem_axi_pkg::bus_req_t  bus_req_o,
    output logic                   bus_req_valid_o,
    input  logic                   bus_req_ready_i,
    input  mem_axi_pkg::mem_rsp_t  bus_rsp_i,
    input  logic                   bus_rsp_valid_i,
    output logic                   bus_rsp_ready_o
);

    logic locked_q;
    logic grant_q;     // port granted last, 1 = data
    logic pick_data;
    logic req_hs;
    logic rsp_done;

    // on a tie the port not served last wins
    assign pick_data = data_valid_i && (!fetch_valid_i || !grant_q);

    assign bus_req_valid_o = !locked_q && (fetch_valid_i || data_valid_i);
    assign fetch_ready_o   = !locked_q && !pick_data && bus_req_ready_i;
    assign data_ready_o    = !locked_q && pick_data && bus_req_ready_i;
    assign req_hs          = bus_req_valid_o && bus_req_ready_i;

    always_comb begin
        bus_req_o = '0;
        if (pick_data) begin
            bus_req_o.req = data_req_i;
            bus_req_o.id  = `MEM_ID_W'(1);
        end else begin
            bus_req_o.req.addr = fetch_addr_i;   // read only, id 0
            bus_req_o.burst    = 1'b1;
        end
    end

    // beats go back to the locked port only
    assign fetch_rsp_o       = bus_rsp_i;
    assign data_rsp_o        = bus_rsp_i;
    assign fetch_rsp_valid_o = locked_q && !grant_q && bus_rsp_valid_i;
    assign data_rsp_valid_o  = locked_q && grant_q && bus_rsp_valid_i;
    assign bus_rsp_ready_o   = locked_q && (grant_q ? data_rsp_ready_i : fetch_rsp_ready_i);
    assign rsp_done          = bus_rsp_valid_i && bus_rsp_ready_o && bus_rsp_i.last;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            locked_q <= 1'b0;
            grant_q  <= 1'b0;
        end else if (req_hs) begin
            locked_q <= 1'b1;
            grant_q  <= pick_data;
        end else if (rsp_done) begin
            locked_q <= 1'b0;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the memory subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_mem_subsys
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mem_subsys 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1

/* test/tb_mem_subsys.sv */
// memory subsystem testbench
`timescale 1ns/1ps
`include "mem_axi_cfg.svh"

module tb_mem_subsys;

    localparam int          OFF_W      = $clog2(`MEM_STRB_W);
    localparam int          IDX_W      = $clog2(`MEM_WORDS);
    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] LINE_BYTES = 32'(`LINE_BEATS * `MEM_STRB_W);
    localparam logic [31:0] MEM_BYTES  = 32'(`MEM_WORDS * `MEM_STRB_W);

    logic                   clk;
    logic                   rst_n;
    logic [`MEM_ADDR_W-1:0] fetch_addr;
    logic                   fetch_valid;
    logic                   fetch_ready;
    mem_axi_pkg::mem_rsp_t  fetch_rsp;
    logic                   fetch_rsp_valid;
    logic                   fetch_rsp_ready;
    mem_axi_pkg::data_req_t data_req;
    logic                   data_valid;
    logic                   data_ready;
    mem_axi_pkg::mem_rsp_t  data_rsp;
    logic                   data_rsp_valid;
    logic                   data_rsp_ready;

    logic [`MEM_DATA_W-1:0] shadow [`MEM_WORDS];   // expected sram contents
    logic [31:0]            rng;
    int                     first_port;            // port of the first beat taken or -1

    mem_subsys_top dut0 (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .fetch_addr_i      (fetch_addr),
        .fetch_valid_i     (fetch_valid),
        .fetch_ready_o     (fetch_ready),
        .fetch_rsp_o       (fetch_rsp),
        .fetch_rsp_valid_o (fetch_rsp_valid),
        .fetch_rsp_ready_i (fetch_rsp_ready),
        .data_req_i        (data_req),
        .data_valid_i      (data_valid),
        .data_ready_o      (data_ready),
        .data_rsp_o        (data_rsp),
        .data_rsp_valid_o  (data_rsp_valid),
        .data_rsp_ready_i  (data_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // bytes with a strobe take the new data
    function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                                input logic [63:0] new_w,
                                                input logic [7:0]  strb);
        logic [63:0] res;
        res = old_w;
        for (int i = 0; i < `MEM_STRB_W; i++) begin
            if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic beyond_mem(input logic [31:0] addr);
        return addr >= MEM_BYTES;
    endfunction

    task automatic fail_text(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        fail_text($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!fetch_rsp_valid)
                else fail_value("fetch_rsp_valid_o", 128'(fetch_rsp_valid), 128'(0));
            assert (!data_rsp_valid)
                else fail_value("data_rsp_valid_o", 128'(data_rsp_valid), 128'(0));
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_fetch(input logic [31:0] addr);
        int   waited;
        logic taken;
        waited      = 0;
        taken       = 1'b0;
        fetch_addr  = addr;
        fetch_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = fetch_ready;
            waited++;
            assert (waited < WAIT_LIMIT) else fail_text("timeout waiting for fetch_ready_o");
            @(posedge clk);
            #1;
        end
        fetch_valid = 1'b0;
    endtask

    task automatic send_data(input logic [31:0] addr, input logic [63:0] wdata,
                             input logic [7:0] wstrb, input logic write);
        int   waited;
        logic taken;
        waited         = 0;
        taken          = 1'b0;
        data_req.addr  = addr;
        data_req.wdata = wdata;
        data_req.wstrb = wstrb;
        data_req.write = write;
        data_valid     = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = data_ready;
            waited++;
            assert (waited < WAIT_LIMIT) else fail_text("timeout waiting for data_ready_o");
            @(posedge clk);
            #1;
        end
        data_valid = 1'b0;
    endtask

    // one response beat from port 1 (data) or 0 (fetch) under random rsp_ready stalls
    task automatic take_beat(input logic port, input logic solo,
                             output mem_axi_pkg::mem_rsp_t beat);
        string                 name;
        string                 other;
        mem_axi_pkg::mem_rsp_t seen;
        mem_axi_pkg::mem_rsp_t cur;
        logic                  cur_valid;
        logic                  cur_ready;
        logic                  other_valid;
        logic                  held;
        logic                  done;
        int                    waited;
        if (port) begin
            name  = "data";
            other = "fetch";
        end else begin
            name  = "fetch";
            other = "data";
        end
        seen   = '0;
        held   = 1'b0;
        done   = 1'b0;
        waited = 0;
        while (!done) begin
            @(negedge clk);
            cur         = port ? data_rsp : fetch_rsp;
            cur_valid   = port ? data_rsp_valid : fetch_rsp_valid;
            cur_ready   = port ? data_rsp_ready : fetch_rsp_ready;
            other_valid = port ? fetch_rsp_valid : data_rsp_valid;
            if (solo) begin
                assert (!other_valid)
                    else fail_value($sformatf("%s_rsp_valid_o", other),
                                    128'(other_valid), 128'(0));
            end
            if (held) begin   // beat stalled last cycle
                assert (cur_valid)
                    else fail_value($sformatf("%s_rsp_valid_o", name),
                                    128'(cur_valid), 128'(1));
                assert (cur == seen)
                    else fail_value($sformatf("%s_rsp_o", name), 128'(cur), 128'(seen));
            end
            if (cur_valid && cur_ready) begin
                beat = cur;
                done = 1'b1;
                if (first_port < 0) first_port = port ? 1 : 0;
            end else if (cur_valid) begin
                held = 1'b1;
                seen = cur;
            end
            waited++;
            assert (waited < WAIT_LIMIT)
                else fail_text($sformatf("timeout waiting for a %s response beat", name));
            @(posedge clk);
            #1;
            // stall about one cycle in three
            if (port) data_rsp_ready = (rand32() % 3) != 0;
            else fetch_rsp_ready = (rand32() % 3) != 0;
        end
    endtask

    task automatic fetch_line(input logic [31:0] addr, input logic solo);
        mem_axi_pkg::mem_rsp_t beat;
        logic [31:0]           a;
        logic [63:0]           exp;
        send_fetch(addr);
        for (int k = 0; k < `LINE_BEATS; k++) begin
            a   = addr + 32'(k * `MEM_STRB_W);
            exp = beyond_mem(a) ? '0 : shadow[a[OFF_W +: IDX_W]];
            take_beat(1'b0, solo, beat);
            assert (beat.err == beyond_mem(a))
                else fail_value("fetch_rsp_o.err", 128'(beat.err), 128'(beyond_mem(a)));
            assert (beat.rdata == exp)
                else fail_value("fetch_rsp_o.rdata", 128'(beat.rdata), 128'(exp));
            assert (beat.last == (k == `LINE_BEATS - 1))
                else fail_value("fetch_rsp_o.last", 128'(beat.last),
                                128'(k == `LINE_BEATS - 1));
        end
    endtask

    task automatic data_access(input logic [31:0] addr, input logic [63:0] wdata,
                               input logic [7:0] wstrb, input logic write,
                               input logic solo);
        mem_axi_pkg::mem_rsp_t beat;
        logic [63:0]           exp;
        logic                  bad;
        bad = beyond_mem(addr);
        send_data(addr, wdata, wstrb, write);
        take_beat(1'b1, solo, beat);
        assert (beat.err == bad) else fail_value("data_rsp_o.err", 128'(beat.err), 128'(bad));
        assert (beat.last) else fail_value("data_rsp_o.last", 128'(beat.last), 128'(1));
        if (write) begin
            if (!bad) shadow[addr[OFF_W +: IDX_W]] =
                merge_bytes(shadow[addr[OFF_W +: IDX_W]], wdata, wstrb);
        end else begin
            exp = bad ? '0 : shadow[addr[OFF_W +: IDX_W]];
            assert (beat.rdata == exp)
                else fail_value("data_rsp_o.rdata", 128'(beat.rdata), 128'(exp));
        end
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] line_addr;
        logic [63:0] wdata;
        logic [7:0]  wstrb;
        int          expect_port;
        rng             = 32'd90104;
        rst_n           = 1'b0;
        fetch_addr      = '0;
        fetch_valid     = 1'b0;
        fetch_rsp_ready = 1'b1;
        data_req        = '0;
        data_valid      = 1'b0;
        data_rsp_ready  = 1'b1;
        first_port      = -1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        expect_quiet(5);   // no beats before the first request

        // known contents everywhere
        for (int i = 0; i < `MEM_WORDS; i++) begin
            data_access(32'(i * `MEM_STRB_W), {rand32(), rand32()}, 8'hff, 1'b1, 1'b1);
        end

        // strobed store then load back
        for (int t = 0; t < 24; t++) begin
            addr  = (rand32() % 32'(`MEM_WORDS)) << OFF_W;
            wdata = {rand32(), rand32()};
            wstrb = 8'(rand32());
            data_access(addr, wdata, wstrb, 1'b1, 1'b1);
            data_access(addr, '0, '0, 1'b0, 1'b1);
        end

        // line refills with nothing after the last beat
        for (int t = 0; t < 10; t++) begin
            line_addr = (rand32() % (MEM_BYTES / LINE_BYTES)) * LINE_BYTES;
            fetch_line(line_addr, 1'b1);
            expect_quiet(3);
        end

        // decode errors past the end of the sram
        addr = MEM_BYTES + ((rand32() % 32'(`MEM_WORDS)) << OFF_W);
        data_access(addr, '0, '0, 1'b0, 1'b1);
        fetch_line(MEM_BYTES + LINE_BYTES * (rand32() % 8), 1'b1);
        expect_quiet(2);
        data_access(addr, {rand32(), rand32()}, 8'hff, 1'b1, 1'b1);
        data_access(addr - MEM_BYTES, '0, '0, 1'b0, 1'b1);   // alias of the bad address stays intact

        // ties between both ports go to the port not served last
        for (int t = 0; t < 6; t++) begin
            if (t % 2 == 0) begin
                fetch_line((rand32() % (MEM_BYTES / LINE_BYTES)) * LINE_BYTES, 1'b1);
                expect_port = 1;
            end else begin
                data_access((rand32() % 32'(`MEM_WORDS)) << OFF_W, '0, '0, 1'b0, 1'b1);
                expect_port = 0;
            end
            line_addr  = (rand32() % (MEM_BYTES / LINE_BYTES)) * LINE_BYTES;
            addr       = (rand32() % 32'(`MEM_WORDS)) << OFF_W;
            first_port = -1;
            fork
                fetch_line(line_addr, 1'b0);
                data_access(addr, '0, '0, 1'b0, 1'b0);
            join
            assert (first_port == expect_port)
                else fail_text($sformatf("first response of trial %0d came from the wrong port",
                                         t));
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
